// ==== Makefile ====
# Verilator build and run for the clock overlay testbench

VERILATOR ?= verilator
TOP       ?= tb_clock_overlay
FILELIST  ?= clock_overlay.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "=== PASS ===" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== clock_overlay.f ====
+incdir+.
clock_overlay_pkg.sv
glyph_req_if.sv
label_tiles.sv
digit_tiles.sv
font_port_arbiter.sv
glyph_shader.sv
clock_overlay_top.sv
tb_clock_overlay.sv

// ==== clock_overlay_defines.svh ====
`ifndef CLOCK_OVERLAY_DEFINES_SVH
`define CLOCK_OVERLAY_DEFINES_SVH

//////////////////////////////////////////////////
// Pixel and font geometry
//////////////////////////////////////////////////

// Screen coordinate width
`define CO_COORD_W 10

// Font ROM address and character base code
`define CO_CODE_W 11

// One glyph row, MSB is the leftmost column
`define CO_GLYPH_W 8

// Time fields, hours minutes seconds
`define CO_FIELD_N 3

`define CO_SCALE_W 2

//////////////////////////////////////////////////
// Colours
//////////////////////////////////////////////////

// Green background
`define CO_BG_COLOR 3'b000

`endif

// ==== clock_overlay_input.txt ====
// x y ringout ampm sistemamilitar habilita, then expected selector_dato selector_digito
// font_addr column colour; all hex, colour 0 green 1 red 3 yellow 4 blue 5 magenta
0bc 03d 0 0 0 0 0 0 443 2 4
0cb 055 0 0 0 0 0 0 69f 0 4
1ab 036 0 0 0 0 0 0 6f0 7 4
1ac 036 0 0 0 0 0 0 000 0 0
173 03c 0 0 0 0 0 0 000 0 0
174 03c 0 0 0 0 0 0 413 0 4
0b8 066 0 0 0 0 0 1 310 0 1
0ed 095 0 0 0 4 0 0 30f 7 5
112 07a 0 0 0 2 1 1 336 3 5
129 082 0 0 0 3 1 0 329 1 1
15d 06e 0 0 0 0 0 0 322 2 1
17c 08d 0 0 0 0 0 0 30d 2 1
193 07d 0 0 0 1 2 1 357 0 5
1c2 07d 0 0 0 1 2 0 347 5 5
0f0 07d 0 0 0 1 0 0 000 0 0
0cf 066 0 0 0 4 0 1 310 7 5
1fd 18a 1 0 0 0 0 0 030 1 1
209 1a9 0 0 0 0 0 0 00f 7 1
20e 190 0 0 0 0 0 0 523 0 4
082 19a 0 1 0 0 0 0 618 1 3
0be 19a 0 1 0 0 0 0 708 1 4
0c8 1a4 0 0 0 0 0 0 70d 6 3
0aa 18b 0 0 0 0 0 0 2f0 1 4
0a0 18a 0 1 1 0 0 0 6d0 6 0
0b7 1a9 0 0 1 0 0 0 2ff 7 0
000 000 0 0 0 0 0 0 000 0 0
0a4 190 0 0 0 0 0 0 000 0 0

// ==== clock_overlay_pkg.sv ====
`include "clock_overlay_defines.svh"

package clock_overlay_pkg;

	// Bit order is blue, green-off, red as on the board
	typedef enum logic [2:0] {
		COL_GREEN   = 3'b000,
		COL_RED     = 3'b001,
		COL_YELLOW  = 3'b011,
		COL_BLUE    = 3'b100,
		COL_MAGENTA = 3'b101,
		COL_WHITE   = 3'b111
	} rgb_color_t;

	// Peer that owns the font port this cycle
	typedef enum logic [1:0] {
		SRC_NONE  = 2'd0,
		SRC_LABEL = 2'd1,
		SRC_DIGIT = 2'd2
	} tile_src_t;

	// Index of a time field
	typedef logic [$clog2(`CO_FIELD_N)-1:0] field_sel_t;

endpackage

// ==== clock_overlay_top.sv ====
`timescale 1ns/1ps
`include "clock_overlay_defines.svh"

module clock_overlay_top (
	input  logic                          clk,
	input  logic                          reset,
	input  logic [`CO_COORD_W-1:0]        pix_x,
	input  logic [`CO_COORD_W-1:0]        pix_y,
	input  logic                          ringout,
	input  logic                          ampm,
	input  logic                          sistemamilitar,
	input  logic [`CO_FIELD_N-1:0]        habilita,
	input  logic [`CO_CODE_W-1:0]         direccion,
	input  logic [`CO_GLYPH_W-1:0]        font_data,
	output clock_overlay_pkg::field_sel_t selector_dato,
	output logic                          selector_digito,
	output logic [`CO_CODE_W-1:0]         font_addr,
	output clock_overlay_pkg::rgb_color_t rgb_text
);
	import clock_overlay_pkg::*;

	logic [`CO_COORD_W-1:0] dx;
	logic [`CO_SCALE_W-1:0] scale_q;
	rgb_color_t             color_q;

	glyph_req_if label_req ();
	glyph_req_if digit_req ();

	//////////////////////////////////////////////////
	// Tile matchers
	//////////////////////////////////////////////////

	label_tiles u_label_tiles (
		.pix_x(pix_x),
		.pix_y(pix_y),
		.ringout(ringout),
		.ampm(ampm),
		.sistemamilitar(sistemamilitar),
		.req(label_req)
	);

	digit_tiles u_digit_tiles (
		.pix_x(pix_x),
		.pix_y(pix_y),
		.habilita(habilita),
		.req(digit_req)
	);

	//////////////////////////////////////////////////
	// Font port and colour
	//////////////////////////////////////////////////

	font_port_arbiter u_arbiter (
		.clk(clk),
		.reset(reset),
		.label_req(label_req),
		.digit_req(digit_req),
		.pix_x(pix_x),
		.pix_y(pix_y),
		.direccion(direccion),
		.selector_dato(selector_dato),
		.selector_digito(selector_digito),
		.font_addr(font_addr),
		.dx(dx),
		.scale_q(scale_q),
		.color_q(color_q)
	);

	glyph_shader u_shader (
		.clk(clk),
		.reset(reset),
		.font_data(font_data),
		.dx(dx),
		.scale_q(scale_q),
		.color_q(color_q),
		.rgb_text(rgb_text)
	);

endmodule

// ==== digit_tiles.sv ====
`timescale 1ns/1ps
`include "clock_overlay_defines.svh"

module digit_tiles (
	input  logic [`CO_COORD_W-1:0] pix_x,
	input  logic [`CO_COORD_W-1:0] pix_y,
	input  logic [`CO_FIELD_N-1:0] habilita,
	glyph_req_if.source            req
);
	import clock_overlay_pkg::*;

	localparam int N_TILES = 8;

	localparam logic [`CO_COORD_W-1:0] DIGIT_Y = 10'd102;
	localparam logic [`CO_COORD_W-1:0] TILE_W  = 10'd24;
	localparam logic [`CO_COORD_W-1:0] TILE_H  = 10'd48;

	// Hours field is the top bit of habilita
	localparam logic [`CO_FIELD_N-1:0] FIELD0_HOT = 3'b100;

	//////////////////////////////////////////////////
	// Time row, hh mm .. ss
	//////////////////////////////////////////////////

	localparam logic [`CO_COORD_W-1:0] TILE_X [N_TILES] = '{
		10'd184, 10'd214, 10'd264, 10'd293, 10'd343, 10'd373, 10'd403, 10'd433
	};
	localparam field_sel_t TILE_FIELD [N_TILES] = '{
		2'd0, 2'd0, 2'd1, 2'd1, 2'd0, 2'd0, 2'd2, 2'd2
	};
	localparam logic TILE_TENS [N_TILES] = '{
		1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0
	};
	// Two fixed glyphs between minutes and seconds
	localparam logic TILE_DIGIT [N_TILES] = '{
		1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1
	};
	localparam logic [`CO_CODE_W-1:0] TILE_CODE [N_TILES] = '{
		11'h000, 11'h000, 11'h000, 11'h000, 11'h320, 11'h300, 11'h000, 11'h000
	};

	always_comb begin
		req.hit       = 1'b0;
		req.origin_x  = '0;
		req.origin_y  = '0;
		req.scale     = 2'd3;
		req.char_base = '0;
		req.color     = COL_RED;
		req.sel_field = '0;
		req.sel_digit = 1'b0;
		req.sel_valid = 1'b0;
		for (int i = N_TILES - 1; i >= 0; i--) begin
			if (pix_x >= TILE_X[i] && pix_x < TILE_X[i] + TILE_W &&
				pix_y >= DIGIT_Y && pix_y < DIGIT_Y + TILE_H) begin
				req.hit       = 1'b1;
				req.origin_x  = TILE_X[i];
				req.origin_y  = DIGIT_Y;
				req.char_base = TILE_CODE[i];
				req.sel_valid = TILE_DIGIT[i];
				req.sel_field = TILE_DIGIT[i] ? TILE_FIELD[i] : '0;
				req.sel_digit = TILE_DIGIT[i] & TILE_TENS[i];
				// Highlight only on an exact one-hot match
				if (TILE_DIGIT[i] && habilita == (FIELD0_HOT >> TILE_FIELD[i]))
					req.color = COL_MAGENTA;
				else
					req.color = COL_RED;
			end
		end
	end

endmodule

// ==== font_port_arbiter.sv ====
`timescale 1ns/1ps
`include "clock_overlay_defines.svh"

module font_port_arbiter (
	input  logic                          clk,
	input  logic                          reset,
	glyph_req_if.arbiter                  label_req,
	glyph_req_if.arbiter                  digit_req,
	input  logic [`CO_COORD_W-1:0]        pix_x,
	input  logic [`CO_COORD_W-1:0]        pix_y,
	input  logic [`CO_CODE_W-1:0]         direccion,
	output clock_overlay_pkg::field_sel_t selector_dato,
	output logic                          selector_digito,
	output logic [`CO_CODE_W-1:0]         font_addr,
	output logic [`CO_COORD_W-1:0]        dx,
	output logic [`CO_SCALE_W-1:0]        scale_q,
	output clock_overlay_pkg::rgb_color_t color_q
);
	import clock_overlay_pkg::*;

	tile_src_t              src_n, src_q;
	logic [`CO_COORD_W-1:0] dx_n, dy_n, dy_q;
	logic [`CO_SCALE_W-1:0] scale_n;
	rgb_color_t             color_n;
	logic [`CO_CODE_W-1:0]  base_n, base_q;
	field_sel_t             sel_field_n;
	logic                   sel_digit_n;
	logic                   sel_valid_n, sel_valid_q;
	logic [`CO_COORD_W-1:0] row_off;
	logic [`CO_CODE_W-1:0]  code_sel;

	//////////////////////////////////////////////////
	// Grant, labels before digits
	//////////////////////////////////////////////////

	always_comb begin
		src_n       = SRC_NONE;
		dx_n        = '0;
		dy_n        = '0;
		scale_n     = 2'd2;
		color_n     = rgb_color_t'(`CO_BG_COLOR);
		base_n      = '0;
		sel_field_n = '0;
		sel_digit_n = 1'b0;
		sel_valid_n = 1'b0;
		if (label_req.hit) begin
			src_n       = SRC_LABEL;
			dx_n        = pix_x - label_req.origin_x;
			dy_n        = pix_y - label_req.origin_y;
			scale_n     = label_req.scale;
			color_n     = label_req.color;
			base_n      = label_req.char_base;
			sel_field_n = label_req.sel_field;
			sel_digit_n = label_req.sel_digit;
			sel_valid_n = label_req.sel_valid;
		end else if (digit_req.hit) begin
			src_n       = SRC_DIGIT;
			dx_n        = pix_x - digit_req.origin_x;
			dy_n        = pix_y - digit_req.origin_y;
			scale_n     = digit_req.scale;
			color_n     = digit_req.color;
			base_n      = digit_req.char_base;
			sel_field_n = digit_req.sel_field;
			sel_digit_n = digit_req.sel_digit;
			sel_valid_n = digit_req.sel_valid;
		end
	end

	// Stage 1 request register
	always_ff @(posedge clk) begin
		if (reset) begin
			src_q           <= SRC_NONE;
			dx              <= '0;
			dy_q            <= '0;
			scale_q         <= 2'd2;
			color_q         <= rgb_color_t'(`CO_BG_COLOR);
			base_q          <= '0;
			selector_dato   <= '0;
			selector_digito <= 1'b0;
			sel_valid_q     <= 1'b0;
		end else begin
			src_q           <= src_n;
			dx              <= dx_n;
			dy_q            <= dy_n;
			scale_q         <= scale_n;
			color_q         <= color_n;
			base_q          <= base_n;
			selector_dato   <= sel_field_n;
			selector_digito <= sel_digit_n;
			sel_valid_q     <= sel_valid_n;
		end
	end

	// Digit code comes back on direccion in this cycle
	assign row_off   = dy_q / scale_q;
	assign code_sel  = (src_q == SRC_DIGIT && sel_valid_q) ? direccion : base_q;
	assign font_addr = code_sel + `CO_CODE_W'(row_off);

endmodule

// ==== glyph_req_if.sv ====
`timescale 1ns/1ps
`include "clock_overlay_defines.svh"

interface glyph_req_if;
	import clock_overlay_pkg::*;

	logic                   hit;
	logic [`CO_COORD_W-1:0] origin_x;
	logic [`CO_COORD_W-1:0] origin_y;
	logic [`CO_SCALE_W-1:0] scale;
	logic [`CO_CODE_W-1:0]  char_base;
	rgb_color_t             color;
	field_sel_t             sel_field;
	logic                   sel_digit;
	// Set only for real digit tiles
	logic                   sel_valid;

	modport source (output hit, origin_x, origin_y, scale, char_base, color,
		sel_field, sel_digit, sel_valid);
	modport arbiter (input hit, origin_x, origin_y, scale, char_base, color,
		sel_field, sel_digit, sel_valid);
endinterface

// ==== glyph_shader.sv ====
`timescale 1ns/1ps
`include "clock_overlay_defines.svh"

module glyph_shader (
	input  logic                          clk,
	input  logic                          reset,
	input  logic [`CO_GLYPH_W-1:0]        font_data,
	input  logic [`CO_COORD_W-1:0]        dx,
	input  logic [`CO_SCALE_W-1:0]        scale_q,
	input  clock_overlay_pkg::rgb_color_t color_q,
	output clock_overlay_pkg::rgb_color_t rgb_text
);
	import clock_overlay_pkg::*;

	logic [`CO_COORD_W-1:0] col_off;
	logic [2:0]             bit_sel;

	// Column 0 sits in the MSB of the row
	assign col_off = dx / scale_q;
	assign bit_sel = 3'(`CO_GLYPH_W - 1) - col_off[2:0];

	always_ff @(posedge clk) begin
		if (reset)
			rgb_text <= rgb_color_t'(`CO_BG_COLOR);
		else if (font_data[bit_sel])
			rgb_text <= color_q;
		else
			rgb_text <= rgb_color_t'(`CO_BG_COLOR);
	end

endmodule

// ==== label_tiles.sv ====
`timescale 1ns/1ps
`include "clock_overlay_defines.svh"

module label_tiles (
	input  logic [`CO_COORD_W-1:0] pix_x,
	input  logic [`CO_COORD_W-1:0] pix_y,
	input  logic                   ringout,
	input  logic                   ampm,
	input  logic                   sistemamilitar,
	glyph_req_if.source            req
);
	import clock_overlay_pkg::*;

	typedef enum logic [2:0] {
		K_BLUE,
		K_BLANK,
		K_RING,
		K_AM,
		K_PM,
		K_SLASH
	} label_kind_t;

	localparam int N_TITLE = 10;
	localparam int N_TILES = 20;

	localparam logic [`CO_COORD_W-1:0] TITLE_Y = 10'd54;
	localparam logic [`CO_COORD_W-1:0] LOW_Y   = 10'd394;
	localparam logic [`CO_COORD_W-1:0] TILE_W  = 10'd16;
	localparam logic [`CO_COORD_W-1:0] TILE_H  = 10'd32;
	localparam logic [`CO_CODE_W-1:0]  RING_ON = 11'h030;

	//////////////////////////////////////////////////
	// Tile table, title first, then ring, then AM/PM
	//////////////////////////////////////////////////

	localparam logic [`CO_COORD_W-1:0] TILE_X [N_TILES] = '{
		10'd183, 10'd203, 10'd223, 10'd243, 10'd263,
		10'd283, 10'd303, 10'd372, 10'd392, 10'd412,
		10'd506, 10'd526, 10'd546, 10'd566, 10'd586,
		10'd128, 10'd148, 10'd168, 10'd188, 10'd208
	};

	localparam logic [`CO_CODE_W-1:0] TILE_CODE [N_TILES] = '{
		11'h440, 11'h690, 11'h610, 11'h000, 11'h4d0,
		11'h650, 11'h730, 11'h410, 11'h7e0, 11'h6f0,
		11'h000, 11'h520, 11'h690, 11'h6e0, 11'h670,
		11'h610, 11'h6d0, 11'h2f0, 11'h700, 11'h6d0
	};

	localparam label_kind_t TILE_KIND [N_TILES] = '{
		K_BLUE, K_BLUE, K_BLUE, K_BLANK, K_BLUE,
		K_BLUE, K_BLUE, K_BLUE, K_BLUE,  K_BLUE,
		K_RING, K_BLUE, K_BLUE, K_BLUE,  K_BLUE,
		K_AM,   K_AM,   K_SLASH, K_PM,   K_PM
	};

	function automatic rgb_color_t kind_color(label_kind_t kind, logic am, logic mil);
		rgb_color_t col;
		case (kind)
			K_BLUE:  col = COL_BLUE;
			K_RING:  col = COL_RED;
			K_AM:    col = mil ? COL_GREEN : (am ? COL_YELLOW : COL_BLUE);
			K_PM:    col = mil ? COL_GREEN : (am ? COL_BLUE : COL_YELLOW);
			K_SLASH: col = mil ? COL_GREEN : COL_BLUE;
			default: col = COL_GREEN;
		endcase
		return col;
	endfunction

	// Walk backwards so the lowest index wins
	always_comb begin
		logic [`CO_COORD_W-1:0] row_y;
		row_y         = TITLE_Y;
		req.hit       = 1'b0;
		req.origin_x  = '0;
		req.origin_y  = '0;
		req.scale     = 2'd2;
		req.char_base = '0;
		req.color     = COL_GREEN;
		req.sel_field = '0;
		req.sel_digit = 1'b0;
		req.sel_valid = 1'b0;
		for (int i = N_TILES - 1; i >= 0; i--) begin
			row_y = (i < N_TITLE) ? TITLE_Y : LOW_Y;
			if (pix_x >= TILE_X[i] && pix_x < TILE_X[i] + TILE_W &&
				pix_y >= row_y && pix_y < row_y + TILE_H) begin
				req.hit       = 1'b1;
				req.origin_x  = TILE_X[i];
				req.origin_y  = row_y;
				req.char_base = (TILE_KIND[i] == K_RING && ringout) ? RING_ON : TILE_CODE[i];
				req.color     = kind_color(TILE_KIND[i], ampm, sistemamilitar);
			end
		end
	end

endmodule

// ==== tb_clock_overlay.sv ====
`timescale 1ns/1ps
`include "clock_overlay_defines.svh"

module tb_clock_overlay;
	import clock_overlay_pkg::*;

	localparam int          FIELDS     = 11;
	localparam int          MAX_LINES  = 64;
	localparam logic [11:0] EMPTY_WORD = 12'hfff;

	// Column order in the stimulus file
	localparam int F_X      = 0;
	localparam int F_Y      = 1;
	localparam int F_RING   = 2;
	localparam int F_AMPM   = 3;
	localparam int F_MIL    = 4;
	localparam int F_HAB    = 5;
	localparam int F_DATO   = 6;
	localparam int F_DIGITO = 7;
	localparam int F_ADDR   = 8;
	localparam int F_COL    = 9;
	localparam int F_COLOR  = 10;

	logic                   clk;
	logic                   reset;
	logic [`CO_COORD_W-1:0] pix_x;
	logic [`CO_COORD_W-1:0] pix_y;
	logic                   ringout;
	logic                   ampm;
	logic                   sistemamilitar;
	logic [`CO_FIELD_N-1:0] habilita;
	logic [`CO_CODE_W-1:0]  direccion;
	logic [`CO_GLYPH_W-1:0] font_data;
	field_sel_t             selector_dato;
	logic                   selector_digito;
	logic [`CO_CODE_W-1:0]  font_addr;
	rgb_color_t             rgb_text;

	logic [11:0]            stim_mem [MAX_LINES*FIELDS];
	logic [`CO_GLYPH_W-1:0] rom [2**`CO_CODE_W];
	int                     n_lines;
	int                     cycle_cnt = 0;
	int                     cycle_limit = 0;
	int                     flight_q[$];

	clock_overlay_top UUT (
		.clk(clk),
		.reset(reset),
		.pix_x(pix_x),
		.pix_y(pix_y),
		.ringout(ringout),
		.ampm(ampm),
		.sistemamilitar(sistemamilitar),
		.habilita(habilita),
		.direccion(direccion),
		.font_data(font_data),
		.selector_dato(selector_dato),
		.selector_digito(selector_digito),
		.font_addr(font_addr),
		.rgb_text(rgb_text)
	);

	//////////////////////////////////////////////////
	// Models of the font ROM and the digit code source
	//////////////////////////////////////////////////

	assign font_data = rom[font_addr];
	assign direccion = 11'h300 + 11'(16 * (2 * selector_dato + selector_digito));

	initial begin : clock_gen
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin : watchdog
		wait (cycle_limit > 0);
		while (cycle_cnt < cycle_limit) begin
			@(posedge clk);
			cycle_cnt++;
		end
		abort_run($sformatf("Timeout after %0d cycles, the pixel stream never drained",
			cycle_cnt));
	end

	function automatic logic [11:0] stim_field(input int line, input int k);
		return stim_mem[line*FIELDS + k];
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_selectors(input field_sel_t exp_dato, input logic exp_digito,
		input int pix);
		if (selector_dato !== exp_dato)
			abort_run($sformatf("MISMATCH selector_dato pixel %0d: expected %h, got %h",
				pix, exp_dato, selector_dato));
		if (selector_digito !== exp_digito)
			abort_run($sformatf("MISMATCH selector_digito pixel %0d: expected %h, got %h",
				pix, exp_digito, selector_digito));
	endtask

	task automatic check_font_addr(input logic [`CO_CODE_W-1:0] exp_addr, input int pix);
		if (font_addr !== exp_addr)
			abort_run($sformatf("MISMATCH font_addr pixel %0d: expected %h, got %h",
				pix, exp_addr, font_addr));
	endtask

	task automatic check_rgb(input rgb_color_t exp_rgb, input int pix);
		if (rgb_text !== exp_rgb)
			abort_run($sformatf("MISMATCH rgb_text pixel %0d: expected %h, got %h",
				pix, exp_rgb, rgb_text));
	endtask

	// Tile colour where the glyph bit is set, background elsewhere
	function automatic rgb_color_t expected_rgb(input int line);
		logic [`CO_CODE_W-1:0] addr;
		logic [2:0]            col;
		rgb_color_t            tile_col;
		addr     = `CO_CODE_W'(stim_field(line, F_ADDR));
		col      = 3'(stim_field(line, F_COL));
		tile_col = rgb_color_t'(3'(stim_field(line, F_COLOR)));
		if (rom[addr][7 - col])
			return tile_col;
		else
			return rgb_color_t'(`CO_BG_COLOR);
	endfunction

	// Negative index stands for the reset state of the pipeline
	task automatic check_stage1(input int line);
		if (line < 0) begin
			check_selectors('0, 1'b0, line);
			check_font_addr('0, line);
		end else begin
			check_selectors(field_sel_t'(stim_field(line, F_DATO)),
				1'(stim_field(line, F_DIGITO)), line + 1);
			check_font_addr(`CO_CODE_W'(stim_field(line, F_ADDR)), line + 1);
		end
	endtask

	task automatic check_stage2(input int line);
		if (line < 0)
			check_rgb(rgb_color_t'(`CO_BG_COLOR), line);
		else
			check_rgb(expected_rgb(line), line + 1);
	endtask

	task automatic drive_pixel(input int line);
		pix_x          = `CO_COORD_W'(stim_field(line, F_X));
		pix_y          = `CO_COORD_W'(stim_field(line, F_Y));
		ringout        = stim_field(line, F_RING) != 0;
		ampm           = stim_field(line, F_AMPM) != 0;
		sistemamilitar = stim_field(line, F_MIL) != 0;
		habilita       = `CO_FIELD_N'(stim_field(line, F_HAB));
	endtask

	//////////////////////////////////////////////////
	// Stimulus and checks
	//////////////////////////////////////////////////

	initial begin : stimulus
		int          idx;
		int          line;
		reset          = 1'b1;
		pix_x          = '0;
		pix_y          = '0;
		ringout        = 1'b0;
		ampm           = 1'b0;
		sistemamilitar = 1'b0;
		habilita       = '0;
		for (int i = 0; i < MAX_LINES*FIELDS; i++)
			stim_mem[i] = EMPTY_WORD;
		$readmemh("clock_overlay_input.txt", stim_mem);
		n_lines = 0;
		while (n_lines < MAX_LINES && stim_mem[n_lines*FIELDS] != EMPTY_WORD)
			n_lines++;
		if (n_lines == 0)
			abort_run("No stimulus lines could be read from clock_overlay_input.txt");
		cycle_limit = n_lines + 20;
		void'($urandom(1));
		for (int a = 0; a < 2**`CO_CODE_W; a++)
			rom[a] = 8'($urandom);

		repeat (3) @(posedge clk);
		#2;
		// Reset still held here
		check_stage1(-1);
		check_stage2(-1);
		flight_q.push_back(-1);
		reset = 1'b0;
		drive_pixel(0);
		flight_q.push_back(0);
		line = 1;

		while (flight_q.size() > 0) begin
			@(posedge clk);
			#2;
			idx = flight_q.pop_front();
			check_stage2(idx);
			if (flight_q.size() > 0)
				check_stage1(flight_q[0]);
			if (line < n_lines) begin
				drive_pixel(line);
				flight_q.push_back(line);
				line++;
			end
		end

		$display("=== PASS ===");
		$finish;
	end

endmodule
